// ==== files.f ====
+incdir+hdl
hdl/harness_pkg.sv
hdl/addr_decode.sv
hdl/boot_rom.sv
hdl/data_sram.sv
hdl/resp_select.sv
hdl/harness_mem_top.sv
tests/harness_props.sv
tests/harness_checker.sv
tests/harness_tb.sv

// ==== hdl/addr_decode.sv ====
`timescale 1ns/100ps
`include "harness_macros.svh"

module addr_decode (
  input  logic                  req_i,
  input  logic                  we_i,
  input  harness_pkg::addr_t    addr_i,
  output logic                  rom_req_o,
  output logic                  sram_req_o,
  output logic                  err_req_o,
  output harness_pkg::rom_idx_t rom_idx_o,
  output harness_pkg::sram_idx_t sram_idx_o
);

  import harness_pkg::*;

  // Byte offset inside a data word
  localparam int unsigned OffsW = $clog2(`HM_STRB_W);

  // Inclusive window bounds
  localparam addr_t RomFirst  = addr_t'(`HM_ROM_BASE);
  localparam addr_t RomLast   = addr_t'(`HM_ROM_BASE + `HM_ROM_WORDS * `HM_STRB_W - 1);
  localparam addr_t SramFirst = addr_t'(`HM_SRAM_BASE);
  localparam addr_t SramLast  = addr_t'(`HM_SRAM_BASE + `HM_SRAM_WORDS * `HM_STRB_W - 1);

  logic in_rom;
  logic in_sram;
  logic rom_hit;

  assign in_rom  = (addr_i >= RomFirst) && (addr_i <= RomLast);
  assign in_sram = (addr_i >= SramFirst) && (addr_i <= SramLast);

  // ROM is read only, a write there is an error
  assign rom_hit = in_rom && !we_i;

  // ------------------------------
  // Region strobes
  // ------------------------------
  // GPIO and unmapped space fall through to the error strobe
  assign rom_req_o  = req_i && rom_hit;
  assign sram_req_o = req_i && in_sram;
  assign err_req_o  = req_i && !rom_hit && !in_sram;

  // Word indices from the bits above the byte offset
  assign rom_idx_o  = addr_i[OffsW +: $bits(rom_idx_t)];
  assign sram_idx_o = addr_i[OffsW +: $bits(sram_idx_t)];

endmodule

// ==== hdl/boot_rom.sv ====
`timescale 1ns/100ps
`include "harness_macros.svh"

module boot_rom (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  harness_pkg::rom_idx_t idx_i,
  output harness_pkg::data_t    rdata_o
);

  import harness_pkg::*;

  localparam int unsigned HalfW = `HM_DATA_W / 2;

  // Low half step between consecutive words
  localparam logic [HalfW-1:0] LowStep = 32'h0101_0101;

  data_t rom_table [`HM_ROM_WORDS];

  // ------------------------------
  // Fixed contents
  // ------------------------------
  // Tag on top, index pattern below
  for (genvar k = 0; k < `HM_ROM_WORDS; k++) begin : g_rom_word
    assign rom_table[k] = {
      HalfW'(`HM_ROM_TAG),
      HalfW'(k) * LowStep
    };
  end

  // ------------------------------
  // Registered read
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= rom_table[idx_i];
    end
  end

endmodule

// ==== hdl/data_sram.sv ====
`timescale 1ns/100ps
`include "harness_macros.svh"

module data_sram (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   we_i,
  input  harness_pkg::sram_idx_t idx_i,
  input  harness_pkg::strb_t     be_i,
  input  harness_pkg::data_t     wdata_i,
  output harness_pkg::data_t     rdata_o
);

  import harness_pkg::*;

  // Storage array
  data_t mem_q [`HM_SRAM_WORDS];

  // ------------------------------
  // Array update
  // ------------------------------
  // Reset loop stands in for a zero initialised memory
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `HM_SRAM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (req_i && we_i) begin
      // Only enabled bytes change
      for (int b = 0; b < `HM_STRB_W; b++) begin
        if (be_i[b]) begin
          mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Read port
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        // Write response carries no data
        rdata_o <= '0;
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

endmodule

// ==== hdl/harness_macros.svh ====
`ifndef HARNESS_MACROS_SVH
`define HARNESS_MACROS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define HM_ADDR_W      32
`define HM_DATA_W      64
`define HM_STRB_W      8

// ------------------------------
// Address map
// ------------------------------
`define HM_ROM_BASE    32'h0001_0000
`define HM_ROM_WORDS   16
`define HM_SRAM_BASE   32'h8000_0000
`define HM_SRAM_WORDS  256
// No device behind this window, accesses error out
`define HM_GPIO_BASE   32'h4000_0000
`define HM_GPIO_SIZE   32'h0000_1000

// Upper half of every boot ROM word
`define HM_ROM_TAG     32'hb007_c0de

`endif

// ==== hdl/harness_mem_top.sv ====
`timescale 1ns/100ps

module harness_mem_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::strb_t be_i,
  input  harness_pkg::data_t wdata_i,
  output logic               rvalid_o,
  output harness_pkg::data_t rdata_o,
  output logic               err_o
);

  import harness_pkg::*;

  // Decoded strobes and indices
  logic      rom_req;
  logic      sram_req;
  logic      err_req;
  rom_idx_t  rom_idx;
  sram_idx_t sram_idx;

  // Target read data
  data_t     rom_rdata;
  data_t     sram_rdata;

  addr_decode i_addr_decode (
    .req_i      ( req_i    ),
    .we_i       ( we_i     ),
    .addr_i     ( addr_i   ),
    .rom_req_o  ( rom_req  ),
    .sram_req_o ( sram_req ),
    .err_req_o  ( err_req  ),
    .rom_idx_o  ( rom_idx  ),
    .sram_idx_o ( sram_idx )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  data_sram i_data_sram (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( sram_req   ),
    .we_i    ( we_i       ),
    .idx_i   ( sram_idx   ),
    .be_i    ( be_i       ),
    .wdata_i ( wdata_i    ),
    .rdata_o ( sram_rdata )
  );

  resp_select i_resp_select (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .rom_req_i    ( rom_req    ),
    .sram_req_i   ( sram_req   ),
    .err_req_i    ( err_req    ),
    .we_i         ( we_i       ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_rdata_i ( sram_rdata ),
    .rvalid_o     ( rvalid_o   ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      )
  );

endmodule

// ==== hdl/harness_pkg.sv ====
`include "harness_macros.svh"

package harness_pkg;

  // ------------------------------
  // Request and response payload
  // ------------------------------

  // Byte address, low bits select the byte inside a word
  typedef logic [`HM_ADDR_W-1:0] addr_t;

  // One full data word
  typedef logic [`HM_DATA_W-1:0] data_t;

  // Byte enables, bit k covers data bits 8k+7 down to 8k
  typedef logic [`HM_STRB_W-1:0] strb_t;

  // ------------------------------
  // Word indices
  // ------------------------------

  // Boot ROM word index
  typedef logic [$clog2(`HM_ROM_WORDS)-1:0] rom_idx_t;

  // Data RAM word index
  typedef logic [$clog2(`HM_SRAM_WORDS)-1:0] sram_idx_t;

endpackage

// ==== hdl/resp_select.sv ====
`timescale 1ns/100ps

module resp_select (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               rom_req_i,
  input  logic               sram_req_i,
  input  logic               err_req_i,
  input  logic               we_i,
  input  harness_pkg::data_t rom_rdata_i,
  input  harness_pkg::data_t sram_rdata_i,
  output logic               rvalid_o,
  output harness_pkg::data_t rdata_o,
  output logic               err_o
);

  // Which target took the request one cycle ago
  logic rom_q;
  logic sram_q;
  logic err_q;
  logic we_q;

  // ------------------------------
  // Request tracking
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rom_q  <= 1'b0;
      sram_q <= 1'b0;
      err_q  <= 1'b0;
      we_q   <= 1'b0;
    end else begin
      rom_q  <= rom_req_i;
      sram_q <= sram_req_i;
      err_q  <= err_req_i;
      we_q   <= we_i;
    end
  end

  // ------------------------------
  // Response
  // ------------------------------
  assign rvalid_o = rom_q || sram_q || err_q;
  assign err_o    = err_q;

  // Zero for writes and errors
  always_comb begin
    rdata_o = '0;
    if (!we_q) begin
      if (rom_q) begin
        rdata_o = rom_rdata_i;
      end else if (sram_q) begin
        rdata_o = sram_rdata_i;
      end
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module harness_tb -f files.f

sim_out=$(./obj_dir/Vharness_tb +verilator+error+limit+1000)
echo "$sim_out"

if grep -q "TEST PASS" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// ==== tests/harness_checker.sv ====
`timescale 1ns/100ps
`include "harness_macros.svh"

module harness_checker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::strb_t be_i,
  input  harness_pkg::data_t wdata_i,
  input  logic               rvalid_i,
  input  harness_pkg::data_t rdata_i,
  input  logic               err_i,
  output int                 data_errs_o,
  output int                 proto_errs_o,
  output int                 pending_o
);

  import harness_pkg::*;

  // Reference RAM contents
  data_t ram_model [`HM_SRAM_WORDS];

  // Outstanding expectations, oldest first
  data_t       exp_data_q [$];
  logic        exp_err_q [$];
  addr_t       exp_addr_q [$];
  int unsigned issue_q [$];

  int unsigned cycle;

  function automatic logic in_window(input addr_t a, input addr_t base, input int unsigned bytes);
    return (a >= base) && ((a - base) < bytes);
  endfunction

  // Sampled at the falling edge, away from DUT updates and TB drive
  always @(negedge clk_i) begin : l_sample
    addr_t     word_addr;
    data_t     exp_data;
    logic      exp_err;
    rom_idx_t  ridx;
    sram_idx_t sidx;
    logic [31:0] lo;
    cycle++;
    if (!rst_ni) begin
      if (rvalid_i !== 1'b0 || err_i !== 1'b0) begin
        $display("FAILED %0t: rvalid %b err %b during reset, expected both low",
                 $time, rvalid_i, err_i);
        data_errs_o++;
      end
      for (int i = 0; i < `HM_SRAM_WORDS; i++) begin
        ram_model[i] = '0;
      end
      exp_data_q.delete();
      exp_err_q.delete();
      exp_addr_q.delete();
      issue_q.delete();
    end else begin
      // ------------------------------
      // Response side
      // ------------------------------
      if (issue_q.size() != 0 && issue_q[0] + 1 == cycle) begin
        exp_data = exp_data_q.pop_front();
        exp_err  = exp_err_q.pop_front();
        word_addr = exp_addr_q.pop_front();
        void'(issue_q.pop_front());
        if (!rvalid_i) begin
          $display("Missing response at %0t for the request to %h", $time, word_addr);
          proto_errs_o++;
        end else if (rdata_i !== exp_data || err_i !== exp_err) begin
          $display("FAILED %0t: response to %h gave rdata %h err %b, expected %h err %b",
                   $time, word_addr, rdata_i, err_i, exp_data, exp_err);
          data_errs_o++;
        end
      end else if (rvalid_i) begin
        $display("Response at %0t with no request outstanding", $time);
        proto_errs_o++;
      end

      // ------------------------------
      // Request side
      // ------------------------------
      if (req_i) begin
        word_addr = {addr_i[31:3], 3'b000};
        exp_data  = '0;
        exp_err   = 1'b0;
        if (in_window(word_addr, `HM_ROM_BASE, `HM_ROM_WORDS * 8) && !we_i) begin
          ridx     = rom_idx_t'((word_addr - `HM_ROM_BASE) >> 3);
          // Index byte repeated in every byte of the low half
          lo       = {4{8'(ridx)}};
          exp_data = {`HM_ROM_TAG, lo};
        end else if (in_window(word_addr, `HM_SRAM_BASE, `HM_SRAM_WORDS * 8)) begin
          sidx = sram_idx_t'((word_addr - `HM_SRAM_BASE) >> 3);
          if (we_i) begin
            for (int b = 0; b < 8; b++) begin
              if (be_i[b]) begin
                ram_model[sidx][8*b +: 8] = wdata_i[8*b +: 8];
              end
            end
          end else begin
            exp_data = ram_model[sidx];
          end
        end else begin
          exp_err = 1'b1;
        end
        exp_data_q.push_back(exp_data);
        exp_err_q.push_back(exp_err);
        exp_addr_q.push_back(word_addr);
        issue_q.push_back(cycle);
      end
    end
    pending_o = issue_q.size();
  end

endmodule

// ==== tests/harness_props.sv ====
`timescale 1ns/100ps

module harness_props (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               req_i,
  input logic               rvalid_i,
  input harness_pkg::data_t rdata_i,
  input logic               err_i
);

  // Failure counts, one per property
  int unsigned follow_fails;
  int unsigned err_fails;
  int unsigned reset_fails;

  // ------------------------------
  // Response timing
  // ------------------------------
  resp_follows_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i == $past(req_i))
    else begin
      $error("rvalid_o does not follow req_i by one cycle");
      follow_fails++;
    end

  // Error responses carry no data
  err_needs_rvalid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_i |-> (rvalid_i && (rdata_i == '0)))
    else begin
      $error("err_o high without rvalid_o or with nonzero rdata_o");
      err_fails++;
    end

  // Quiet outputs while reset is held
  quiet_in_reset : assert property (@(posedge clk_i)
    !rst_ni |-> (!rvalid_i && !err_i))
    else begin
      $error("rvalid_o or err_o high during reset");
      reset_fails++;
    end

endmodule

bind harness_mem_top harness_props i_harness_props (
  .clk_i    ( clk_i    ),
  .rst_ni   ( rst_ni   ),
  .req_i    ( req_i    ),
  .rvalid_i ( rvalid_o ),
  .rdata_i  ( rdata_o  ),
  .err_i    ( err_o    )
);

// ==== tests/harness_tb.sv ====
`timescale 1ns/100ps
`include "harness_macros.svh"

module harness_tb;

  import harness_pkg::*;

  logic  clk_i;
  logic  rst_ni;
  logic  req;
  logic  we;
  addr_t addr;
  strb_t be;
  data_t wdata;
  logic  rvalid;
  data_t rdata;
  logic  err;

  int data_errs;
  int proto_errs;
  int pending;

  logic [31:0] rng_state = 32'h54f1_370a;

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  always #5 clk_i = ~clk_i;

  harness_mem_top harness_mem_top_i (
    .clk_i    ( clk_i  ),
    .rst_ni   ( rst_ni ),
    .req_i    ( req    ),
    .we_i     ( we     ),
    .addr_i   ( addr   ),
    .be_i     ( be     ),
    .wdata_i  ( wdata  ),
    .rvalid_o ( rvalid ),
    .rdata_o  ( rdata  ),
    .err_o    ( err    )
  );

  harness_checker i_checker (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req        ),
    .we_i         ( we         ),
    .addr_i       ( addr       ),
    .be_i         ( be         ),
    .wdata_i      ( wdata      ),
    .rvalid_i     ( rvalid     ),
    .rdata_i      ( rdata      ),
    .err_i        ( err        ),
    .data_errs_o  ( data_errs  ),
    .proto_errs_o ( proto_errs ),
    .pending_o    ( pending    )
  );

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    logic [7:0]  word;
    logic        follow_read;
    addr_t       last_addr;
    int unsigned gap;
    int unsigned wait_cycles;
    int unsigned assert_fails;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    be = '0;
    wdata = '0;
    follow_read = 1'b0;
    last_addr = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // ------------------------------
    // Random traffic
    // ------------------------------
    for (int i = 0; i < 2000; i++) begin
      r = lcg_next();
      s = lcg_next();
      we = r[28];
      be = s[31:24];
      wdata = {lcg_next(), 32'h0};
      wdata[31:0] = lcg_next();
      if (i < 8) begin
        // Fresh RAM words read back as zero
        we = 1'b0;
        addr = addr_t'(`HM_SRAM_BASE) + (addr_t'(i) << 3);
      end else if (follow_read) begin
        we = 1'b0;
        addr = last_addr;
      end else begin
        case (r[31:30])
          2'd0: addr = addr_t'(`HM_ROM_BASE) + addr_t'({s[19:16], s[2:0]});
          2'd1: begin
            word = r[29] ? {3'b000, s[20:16]} : s[23:16];
            addr = addr_t'(`HM_SRAM_BASE) + addr_t'({word, s[2:0]});
          end
          2'd2: addr = addr_t'(`HM_GPIO_BASE) + addr_t'(s[11:0]);
          default: begin
            case (s[1:0])
              2'd0: addr = addr_t'(`HM_ROM_BASE) + 32'h80 + addr_t'(s[6:3]);
              2'd1: addr = addr_t'(`HM_SRAM_BASE) + 32'h800 + addr_t'(s[10:3]);
              2'd2: addr = addr_t'(s[15:0]);
              default: addr = {4'h2, s[27:0]};
            endcase
          end
        endcase
      end
      // A RAM write is sometimes read back on the very next cycle
      follow_read = !follow_read && (r[31:30] == 2'd1) && we && r[23] && (i >= 8);
      last_addr = addr;
      gap = (!follow_read && r[27:26] == 2'd0) ? int'(r[25:24]) + 1 : 0;
      req = 1'b1;
      @(posedge clk_i);
      #1;
      req = 1'b0;
      we = 1'b0;
      repeat (gap) begin
        @(posedge clk_i);
        #1;
      end
    end

    // Drain the last responses
    wait_cycles = 0;
    while (pending != 0 && wait_cycles < 16) begin
      @(posedge clk_i);
      wait_cycles++;
    end
    repeat (2) @(posedge clk_i);
    assert_fails = harness_mem_top_i.i_harness_props.follow_fails +
                   harness_mem_top_i.i_harness_props.err_fails +
                   harness_mem_top_i.i_harness_props.reset_fails;
    if (pending != 0) begin
      $display("Timeout: %0d responses never arrived after the last request", pending);
    end
    $display("Error counts: %0d data, %0d protocol, %0d assertion",
             data_errs, proto_errs, assert_fails);
    if (pending == 0 && data_errs == 0 && proto_errs == 0 && assert_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
